/* Bender.yml */
package:
  name: soc_periph_fabric

sources:
  - design/periph_pkg.sv
  - design/periph_bus_if.sv
  - design/timer_core.sv
  - design/timer_csr.sv
  - design/xbar_router.sv
  - design/soc_periph_fabric.sv
  - target: test
    files:
      - verif/tb_soc_periph_fabric.sv

/* design/periph_bus_if.sv */
// Request/response link between the router and the timer register block

`timescale 1ns/1ps

interface periph_bus_if;

    // Request side, valid/ready handshake
    logic                                req_valid;
    logic                                req_ready;
    logic                                req_write;
    logic [periph_pkg::TIMER_ADDR_W-1:0] req_addr;
    periph_pkg::data_t                   req_wdata;

    // Response is a single-cycle pulse
    logic                                rsp_valid;
    periph_pkg::data_t                   rsp_rdata;
    periph_pkg::resp_e                   rsp_err;

    modport initiator (
        output req_valid, req_write, req_addr, req_wdata,
        input  req_ready, rsp_valid, rsp_rdata, rsp_err
    );

    modport target (
        input  req_valid, req_write, req_addr, req_wdata,
        output req_ready, rsp_valid, rsp_rdata, rsp_err
    );

endinterface

/* design/periph_pkg.sv */
// Shared widths, address map, target and timer register encodings, response type

package periph_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // Response status, one bit on the wire
    typedef enum logic {
        RESP_OKAY = 1'b0,
        RESP_ERR  = 1'b1
    } resp_e;

    // UART register window
    localparam addr_t UART_BASE   = 32'h4000_0000;
    localparam addr_t UART_SIZE   = 32'h0000_2000;
    localparam int    UART_ADDR_W = 13;

    // Machine timer window
    localparam addr_t TIMER_BASE   = 32'h4001_0000;
    localparam addr_t TIMER_SIZE   = 32'h0000_0100;
    localparam int    TIMER_ADDR_W = 8;

    // Memory takes the whole upper half
    localparam addr_t MEM_BASE   = 32'h8000_0000;
    localparam int    MEM_ADDR_W = 31;

    // Address decode result
    typedef enum logic [1:0] {
        TGT_UART,
        TGT_TIMER,
        TGT_MEM,
        TGT_NONE
    } target_e;

    // Word offsets inside the timer window
    typedef enum logic [TIMER_ADDR_W-1:0] {
        TMR_CTRL     = 8'h00,
        TMR_PRESCALE = 8'h04,
        TMR_TIME_LO  = 8'h08,
        TMR_TIME_HI  = 8'h0C,
        TMR_CMP_LO   = 8'h10,
        TMR_CMP_HI   = 8'h14
    } timer_reg_e;

    // Router transaction FSM
    typedef enum logic {
        ST_IDLE,
        ST_WAIT
    } router_state_e;

endpackage

/* design/soc_periph_fabric.sv */
// Peripheral fabric top with router, timer registers and timer counter

`timescale 1ns/1ps

module soc_periph_fabric #(
    parameter int PRESCALE_W = 16
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,

    // Host request port
    input  logic                                host_req_valid_i,
    input  logic                                host_req_write_i,
    input  periph_pkg::addr_t                   host_req_addr_i,
    input  periph_pkg::data_t                   host_req_wdata_i,
    output logic                                host_req_ready_o,
    output logic                                host_rsp_valid_o,
    output periph_pkg::data_t                   host_rsp_rdata_o,
    output logic                                host_rsp_err_o,

    // External UART registers
    output logic                                uart_req_valid_o,
    input  logic                                uart_req_ready_i,
    output logic                                uart_req_write_o,
    output logic [periph_pkg::UART_ADDR_W-1:0]  uart_req_addr_o,
    output periph_pkg::data_t                   uart_req_wdata_o,
    input  logic                                uart_rsp_valid_i,
    input  periph_pkg::data_t                   uart_rsp_rdata_i,
    input  logic                                uart_rsp_err_i,

    // External memory
    output logic                                mem_req_valid_o,
    input  logic                                mem_req_ready_i,
    output logic                                mem_req_write_o,
    output logic [periph_pkg::MEM_ADDR_W-1:0]   mem_req_addr_o,
    output periph_pkg::data_t                   mem_req_wdata_o,
    input  logic                                mem_rsp_valid_i,
    input  periph_pkg::data_t                   mem_rsp_rdata_i,
    input  logic                                mem_rsp_err_i,

    // Machine timer outputs
    output logic [63:0]                         time_o,
    output logic                                timer_irq_o
);

    logic                  timer_en;
    logic [PRESCALE_W-1:0] timer_prescale;
    logic [63:0]           timer_cmp;

    periph_bus_if timer_bus ();

    xbar_router router_inst (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .host_req_valid_i (host_req_valid_i),
        .host_req_write_i (host_req_write_i),
        .host_req_addr_i  (host_req_addr_i),
        .host_req_wdata_i (host_req_wdata_i),
        .host_req_ready_o (host_req_ready_o),
        .host_rsp_valid_o (host_rsp_valid_o),
        .host_rsp_rdata_o (host_rsp_rdata_o),
        .host_rsp_err_o   (host_rsp_err_o),
        .timer_bus        (timer_bus.initiator),
        .uart_req_valid_o (uart_req_valid_o),
        .uart_req_ready_i (uart_req_ready_i),
        .uart_req_write_o (uart_req_write_o),
        .uart_req_addr_o  (uart_req_addr_o),
        .uart_req_wdata_o (uart_req_wdata_o),
        .uart_rsp_valid_i (uart_rsp_valid_i),
        .uart_rsp_rdata_i (uart_rsp_rdata_i),
        .uart_rsp_err_i   (uart_rsp_err_i),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_req_write_o  (mem_req_write_o),
        .mem_req_addr_o   (mem_req_addr_o),
        .mem_req_wdata_o  (mem_req_wdata_o),
        .mem_rsp_valid_i  (mem_rsp_valid_i),
        .mem_rsp_rdata_i  (mem_rsp_rdata_i),
        .mem_rsp_err_i    (mem_rsp_err_i)
    );

    timer_csr #(
        .PRESCALE_W (PRESCALE_W)
    ) timer_csr_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .bus        (timer_bus.target),
        .time_i     (time_o),
        .enable_o   (timer_en),
        .prescale_o (timer_prescale),
        .cmp_o      (timer_cmp)
    );

    timer_core #(
        .PRESCALE_W (PRESCALE_W)
    ) timer_core_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .enable_i   (timer_en),
        .prescale_i (timer_prescale),
        .cmp_i      (timer_cmp),
        .time_o     (time_o),
        .irq_o      (timer_irq_o)
    );

endmodule

/* design/timer_core.sv */
// Prescaled 64-bit time counter with compare interrupt

`timescale 1ns/1ps

module timer_core #(
    parameter int PRESCALE_W = 16
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  enable_i,
    input  logic [PRESCALE_W-1:0] prescale_i,
    input  logic [63:0]           cmp_i,
    output logic [63:0]           time_o,
    output logic                  irq_o
);

    logic [PRESCALE_W-1:0] div_q;
    logic [63:0]           time_q;

    // One tick every prescale+1 cycles
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            div_q  <= '0;
            time_q <= '0;
        end else if (!enable_i) begin
            div_q <= '0;
        end else if (div_q >= prescale_i) begin
            // also catches a prescale lowered below the running count
            div_q  <= '0;
            time_q <= time_q + 64'd1;
        end else begin
            div_q <= div_q + 1'b1;
        end
    end

    assign time_o = time_q;

    // Level interrupt while time has reached compare
    assign irq_o = enable_i && (time_q >= cmp_i);

endmodule

/* design/timer_csr.sv */
// Timer register block with control, prescale and compare registers and time readback

`timescale 1ns/1ps

module timer_csr #(
    parameter int PRESCALE_W = 16
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    periph_bus_if.target          bus,
    input  logic [63:0]           time_i,
    output logic                  enable_o,
    output logic [PRESCALE_W-1:0] prescale_o,
    output logic [63:0]           cmp_o
);

    periph_pkg::timer_reg_e reg_sel;
    logic                   en_q;
    logic [PRESCALE_W-1:0]  prescale_q;
    logic [63:0]            cmp_q;

    periph_pkg::data_t      rd_data;
    periph_pkg::resp_e      reg_err;

    logic                   rsp_valid_q;
    periph_pkg::data_t      rsp_rdata_q;
    periph_pkg::resp_e      rsp_err_q;

    // Never stalls; every request answers on the next cycle
    assign bus.req_ready = 1'b1;
    assign reg_sel       = periph_pkg::timer_reg_e'(bus.req_addr);

    // Read mux and offset check
    always_comb begin
        rd_data = '0;
        reg_err = periph_pkg::RESP_OKAY;
        case (reg_sel)
            periph_pkg::TMR_CTRL:     rd_data = periph_pkg::data_t'(en_q);
            periph_pkg::TMR_PRESCALE: rd_data = periph_pkg::data_t'(prescale_q);
            periph_pkg::TMR_TIME_LO:  rd_data = time_i[31:0];
            periph_pkg::TMR_TIME_HI:  rd_data = time_i[63:32];
            periph_pkg::TMR_CMP_LO:   rd_data = cmp_q[31:0];
            periph_pkg::TMR_CMP_HI:   rd_data = cmp_q[63:32];
            default:                  reg_err = periph_pkg::RESP_ERR;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            en_q        <= 1'b0;
            prescale_q  <= '0;
            cmp_q       <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= bus.req_valid;
            if (bus.req_valid && bus.req_write) begin
                // Time words are read-only, writes there are dropped
                case (reg_sel)
                    periph_pkg::TMR_CTRL:     en_q          <= bus.req_wdata[0];
                    periph_pkg::TMR_PRESCALE: prescale_q    <= bus.req_wdata[PRESCALE_W-1:0];
                    periph_pkg::TMR_CMP_LO:   cmp_q[31:0]   <= bus.req_wdata;
                    periph_pkg::TMR_CMP_HI:   cmp_q[63:32]  <= bus.req_wdata;
                    default:                  en_q          <= en_q;
                endcase
            end
        end
    end

    // Response payload
    always_ff @(posedge clk_i) begin
        if (bus.req_valid) begin
            rsp_rdata_q <= bus.req_write ? '0 : rd_data;
            rsp_err_q   <= reg_err;
        end
    end

    assign bus.rsp_valid = rsp_valid_q;
    assign bus.rsp_rdata = rsp_rdata_q;
    assign bus.rsp_err   = rsp_err_q;

    assign enable_o   = en_q;
    assign prescale_o = prescale_q;
    assign cmp_o      = cmp_q;

endmodule

/* design/xbar_router.sv */
// Address decoder and single-transaction router from the host port to UART, timer and memory

`timescale 1ns/1ps

module xbar_router (
    input  logic                                clk_i,
    input  logic                                rst_n_i,

    // Host port
    input  logic                                host_req_valid_i,
    input  logic                                host_req_write_i,
    input  periph_pkg::addr_t                   host_req_addr_i,
    input  periph_pkg::data_t                   host_req_wdata_i,
    output logic                                host_req_ready_o,
    output logic                                host_rsp_valid_o,
    output periph_pkg::data_t                   host_rsp_rdata_o,
    output logic                                host_rsp_err_o,

    // Internal timer
    periph_bus_if.initiator                     timer_bus,

    // UART register port
    output logic                                uart_req_valid_o,
    input  logic                                uart_req_ready_i,
    output logic                                uart_req_write_o,
    output logic [periph_pkg::UART_ADDR_W-1:0]  uart_req_addr_o,
    output periph_pkg::data_t                   uart_req_wdata_o,
    input  logic                                uart_rsp_valid_i,
    input  periph_pkg::data_t                   uart_rsp_rdata_i,
    input  logic                                uart_rsp_err_i,

    // Memory port
    output logic                                mem_req_valid_o,
    input  logic                                mem_req_ready_i,
    output logic                                mem_req_write_o,
    output logic [periph_pkg::MEM_ADDR_W-1:0]   mem_req_addr_o,
    output periph_pkg::data_t                   mem_req_wdata_o,
    input  logic                                mem_rsp_valid_i,
    input  periph_pkg::data_t                   mem_rsp_rdata_i,
    input  logic                                mem_rsp_err_i
);

    periph_pkg::router_state_e state_q;
    periph_pkg::target_e       dec_tgt;
    periph_pkg::target_e       tgt_q;
    periph_pkg::addr_t         dec_offset;
    periph_pkg::addr_t         offset_q;
    periph_pkg::data_t         wdata_q;
    logic                      write_q;
    logic                      req_pend_q;

    logic                      sel_ready;
    logic                      sel_rsp_valid;
    periph_pkg::data_t         sel_rsp_rdata;
    periph_pkg::resp_e         sel_rsp_err;

    logic                      rsp_valid_q;
    periph_pkg::data_t         rsp_rdata_q;
    periph_pkg::resp_e         rsp_err_q;

    logic                      accept;

    assign host_req_ready_o = (state_q == periph_pkg::ST_IDLE);
    assign accept           = host_req_valid_i && host_req_ready_o;

    // Map lookup and base removal
    always_comb begin
        dec_tgt    = periph_pkg::TGT_NONE;
        dec_offset = host_req_addr_i;
        if (host_req_addr_i >= periph_pkg::UART_BASE &&
            host_req_addr_i <  periph_pkg::UART_BASE + periph_pkg::UART_SIZE) begin
            dec_tgt    = periph_pkg::TGT_UART;
            dec_offset = host_req_addr_i - periph_pkg::UART_BASE;
        end else if (host_req_addr_i >= periph_pkg::TIMER_BASE &&
                     host_req_addr_i <  periph_pkg::TIMER_BASE + periph_pkg::TIMER_SIZE) begin
            dec_tgt    = periph_pkg::TGT_TIMER;
            dec_offset = host_req_addr_i - periph_pkg::TIMER_BASE;
        end else if (host_req_addr_i >= periph_pkg::MEM_BASE) begin
            dec_tgt    = periph_pkg::TGT_MEM;
            dec_offset = host_req_addr_i - periph_pkg::MEM_BASE;
        end
    end

    // Handshake and response of the target in flight
    always_comb begin
        sel_ready     = 1'b0;
        sel_rsp_valid = 1'b0;
        sel_rsp_rdata = '0;
        sel_rsp_err   = periph_pkg::RESP_OKAY;
        case (tgt_q)
            periph_pkg::TGT_UART: begin
                sel_ready     = uart_req_ready_i;
                sel_rsp_valid = uart_rsp_valid_i;
                sel_rsp_rdata = uart_rsp_rdata_i;
                sel_rsp_err   = periph_pkg::resp_e'(uart_rsp_err_i);
            end
            periph_pkg::TGT_TIMER: begin
                sel_ready     = timer_bus.req_ready;
                sel_rsp_valid = timer_bus.rsp_valid;
                sel_rsp_rdata = timer_bus.rsp_rdata;
                sel_rsp_err   = timer_bus.rsp_err;
            end
            periph_pkg::TGT_MEM: begin
                sel_ready     = mem_req_ready_i;
                sel_rsp_valid = mem_rsp_valid_i;
                sel_rsp_rdata = mem_rsp_rdata_i;
                sel_rsp_err   = periph_pkg::resp_e'(mem_rsp_err_i);
            end
            default: begin
                sel_ready = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= periph_pkg::ST_IDLE;
            tgt_q       <= periph_pkg::TGT_NONE;
            req_pend_q  <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;
            case (state_q)
                periph_pkg::ST_IDLE: begin
                    if (accept) begin
                        state_q <= periph_pkg::ST_WAIT;
                        tgt_q   <= dec_tgt;
                        // Unmapped address answers straight away
                        if (dec_tgt == periph_pkg::TGT_NONE) begin
                            rsp_valid_q <= 1'b1;
                        end else begin
                            req_pend_q <= 1'b1;
                        end
                    end
                end
                periph_pkg::ST_WAIT: begin
                    if (req_pend_q && sel_ready) begin
                        req_pend_q <= 1'b0;
                    end
                    if (tgt_q == periph_pkg::TGT_NONE) begin
                        state_q <= periph_pkg::ST_IDLE;
                    end else if (sel_rsp_valid) begin
                        rsp_valid_q <= 1'b1;
                        req_pend_q  <= 1'b0;
                        state_q     <= periph_pkg::ST_IDLE;
                    end
                end
                default: state_q <= periph_pkg::ST_IDLE;
            endcase
        end
    end

    // Latched request and response payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            write_q  <= host_req_write_i;
            offset_q <= dec_offset;
            wdata_q  <= host_req_wdata_i;
            if (dec_tgt == periph_pkg::TGT_NONE) begin
                rsp_rdata_q <= '0;
                rsp_err_q   <= periph_pkg::RESP_ERR;
            end
        end else if (state_q == periph_pkg::ST_WAIT && sel_rsp_valid) begin
            rsp_rdata_q <= sel_rsp_rdata;
            rsp_err_q   <= sel_rsp_err;
        end
    end

    assign uart_req_valid_o = req_pend_q && (tgt_q == periph_pkg::TGT_UART);
    assign uart_req_write_o = write_q;
    assign uart_req_addr_o  = offset_q[periph_pkg::UART_ADDR_W-1:0];
    assign uart_req_wdata_o = wdata_q;

    assign timer_bus.req_valid = req_pend_q && (tgt_q == periph_pkg::TGT_TIMER);
    assign timer_bus.req_write = write_q;
    assign timer_bus.req_addr  = offset_q[periph_pkg::TIMER_ADDR_W-1:0];
    assign timer_bus.req_wdata = wdata_q;

    assign mem_req_valid_o = req_pend_q && (tgt_q == periph_pkg::TGT_MEM);
    assign mem_req_write_o = write_q;
    assign mem_req_addr_o  = offset_q[periph_pkg::MEM_ADDR_W-1:0];
    assign mem_req_wdata_o = wdata_q;

    assign host_rsp_valid_o = rsp_valid_q;
    assign host_rsp_rdata_o = rsp_rdata_q;
    assign host_rsp_err_o   = rsp_err_q;

endmodule

/* soc_periph_fabric.f */
design/periph_pkg.sv
design/periph_bus_if.sv
design/timer_core.sv
design/timer_csr.sv
design/xbar_router.sv
design/soc_periph_fabric.sv
verif/tb_soc_periph_fabric.sv

/* verif/stim_input.txt */
# op addr wdata exp_rdata exp_err, all hex; op W write, R read and compare, L write with irq low
# T timer read that must increase, I wait for irq with wdata as the cycle limit
R 40000010 00000000 a5a50010 0
W 40000024 12345678 00000000 0
R 40001ffc 00000000 a5a51ffc 0
W 80000100 deadbeef 00000000 0
W 80001000 0badf00d 00000000 0
W fffffffc 13579bdf 00000000 0
R 80000100 00000000 deadbeef 0
R 80001000 00000000 0badf00d 0
R fffffffc 00000000 13579bdf 0
R 20000000 00000000 00000000 1
W 40002000 11111111 00000000 1
R 40010020 00000000 00000000 1
W 40010004 00000001 00000000 0
R 40010004 00000000 00000001 0
W 40010014 00000000 00000000 0
W 40010010 00000005 00000000 0
R 40010010 00000000 00000005 0
W 40010000 00000001 00000000 0
R 40010000 00000000 00000001 0
T 40010008 00000000 00000000 0
T 40010008 00000000 00000000 0
I 00000000 00000040 00000000 0
W 40010010 ffffffff 00000000 0
L 40010014 ffffffff 00000000 0
R 40010014 00000000 ffffffff 0
W 4001000c 12345678 00000000 0
R 4001000c 00000000 00000000 0

/* verif/tb_soc_periph_fabric.sv */
// Testbench for the peripheral fabric with UART and memory responder models and vector checks

`timescale 1ns/1ps

module tb_soc_periph_fabric;

    logic                                clk_i = 1'b0;
    logic                                rst_n_i;
    logic                                host_req_valid_i;
    logic                                host_req_write_i;
    periph_pkg::addr_t                   host_req_addr_i;
    periph_pkg::data_t                   host_req_wdata_i;
    logic                                host_req_ready_o;
    logic                                host_rsp_valid_o;
    periph_pkg::data_t                   host_rsp_rdata_o;
    logic                                host_rsp_err_o;
    logic                                uart_req_valid_o;
    logic                                uart_req_ready_i;
    logic                                uart_req_write_o;
    logic [periph_pkg::UART_ADDR_W-1:0]  uart_req_addr_o;
    periph_pkg::data_t                   uart_req_wdata_o;
    logic                                uart_rsp_valid_i;
    periph_pkg::data_t                   uart_rsp_rdata_i;
    logic                                uart_rsp_err_i;
    logic                                mem_req_valid_o;
    logic                                mem_req_ready_i;
    logic                                mem_req_write_o;
    logic [periph_pkg::MEM_ADDR_W-1:0]   mem_req_addr_o;
    periph_pkg::data_t                   mem_req_wdata_o;
    logic                                mem_rsp_valid_i;
    periph_pkg::data_t                   mem_rsp_rdata_i;
    logic                                mem_rsp_err_i;
    logic [63:0]                         time_o;
    logic                                timer_irq_o;

    integer            seed = 53349;
    int                cycle_count = 0;
    int                cycle_limit = 200;
    periph_pkg::addr_t cur_addr = '0;
    logic              cur_write = 1'b0;
    periph_pkg::data_t cur_wdata = '0;
    periph_pkg::data_t mem_store [periph_pkg::addr_t];

    // One entry per vector line
    logic [7:0]        vec_op [$];
    periph_pkg::addr_t vec_addr [$];
    periph_pkg::data_t vec_wdata [$];
    periph_pkg::data_t vec_rdata [$];
    logic              vec_err [$];

    soc_periph_fabric #(.PRESCALE_W(16)) dut0 (.*);

    always #50 clk_i = ~clk_i;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_data(input periph_pkg::data_t got, input periph_pkg::data_t exp,
                              input string name);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input periph_pkg::addr_t got, input periph_pkg::addr_t exp,
                              input string name);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_resp(input periph_pkg::resp_e got, input periph_pkg::resp_e exp,
                              input string name);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s = %s, expected %s",
                                $time, name, got.name(), exp.name()));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s = %b, expected %b", $time, name, got, exp));
        end
    endtask

    // Lines starting with # are skipped
    task automatic load_vectors();
        int                fd;
        int                ch;
        int                n;
        periph_pkg::addr_t a;
        periph_pkg::data_t w;
        periph_pkg::data_t r;
        logic [3:0]        e;
        fd = $fopen("verif/stim_input.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file verif/stim_input.txt");
        end
        ch = $fgetc(fd);
        while (ch != -1) begin
            if (ch == "#") begin
                while (ch != "\n" && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (ch == "W" || ch == "R" || ch == "T" || ch == "I" || ch == "L") begin
                n = $fscanf(fd, "%h %h %h %h", a, w, r, e);
                if (n != 4) begin
                    abort_run("badly formed line in the stimulus file");
                end
                vec_op.push_back(ch[7:0]);
                vec_addr.push_back(a);
                vec_wdata.push_back(w);
                vec_rdata.push_back(r);
                vec_err.push_back(e[0]);
            end
            ch = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    // One host transaction, response sampled on the falling edge
    task automatic host_access(input logic write, input periph_pkg::addr_t addr,
                               input periph_pkg::data_t wdata,
                               output periph_pkg::data_t rdata, output periph_pkg::resp_e err,
                               output logic irq_at_rsp, output logic ext_seen);
        ext_seen = 1'b0;
        @(negedge clk_i);
        cur_addr         = addr;
        cur_write        = write;
        cur_wdata        = wdata;
        host_req_valid_i = 1'b1;
        host_req_write_i = write;
        host_req_addr_i  = addr;
        host_req_wdata_i = wdata;
        while (host_req_ready_o !== 1'b1) begin
            @(negedge clk_i);
        end
        @(negedge clk_i);
        host_req_valid_i = 1'b0;
        while (host_rsp_valid_o !== 1'b1) begin
            check_flag(host_req_ready_o, 1'b0, "host_req_ready_o");
            if (uart_req_valid_o || mem_req_valid_o) begin
                ext_seen = 1'b1;
            end
            @(negedge clk_i);
        end
        // Unmapped accesses answer before the loop body ever runs
        if (uart_req_valid_o || mem_req_valid_o) begin
            ext_seen = 1'b1;
        end
        rdata      = host_rsp_rdata_o;
        err        = periph_pkg::resp_e'(host_rsp_err_o);
        irq_at_rsp = timer_irq_o;
    endtask

    task automatic wait_for_irq(input int max_cycles);
        int n;
        n = 0;
        while (timer_irq_o !== 1'b1 && n < max_cycles) begin
            @(negedge clk_i);
            n++;
        end
        if (timer_irq_o !== 1'b1) begin
            abort_run($sformatf("timer interrupt did not rise within %0d cycles", max_cycles));
        end
    endtask

    // UART registers answer reads with offset XOR a fixed pattern
    always begin : uart_responder
        int                delay;
        periph_pkg::addr_t offset;
        logic              wr;
        @(negedge clk_i);
        if (uart_req_valid_o === 1'b1) begin
            delay = $random(seed) & 3;
            repeat (delay) @(negedge clk_i);
            offset = periph_pkg::addr_t'(uart_req_addr_o);
            check_addr(offset, cur_addr - periph_pkg::UART_BASE, "uart_req_addr_o");
            check_flag(uart_req_write_o, cur_write, "uart_req_write_o");
            wr = uart_req_write_o;
            if (wr) begin
                check_data(uart_req_wdata_o, cur_wdata, "uart_req_wdata_o");
            end
            uart_req_ready_i = 1'b1;
            @(negedge clk_i);
            uart_req_ready_i = 1'b0;
            delay = $random(seed) & 3;
            repeat (delay) @(negedge clk_i);
            uart_rsp_rdata_i = wr ? '0 : (offset ^ 32'hA5A5_0000);
            uart_rsp_valid_i = 1'b1;
            @(negedge clk_i);
            uart_rsp_valid_i = 1'b0;
        end
    end

    always begin : mem_responder
        int                delay;
        periph_pkg::addr_t offset;
        logic              wr;
        periph_pkg::data_t wdata;
        @(negedge clk_i);
        if (mem_req_valid_o === 1'b1) begin
            delay = $random(seed) & 3;
            repeat (delay) @(negedge clk_i);
            offset = periph_pkg::addr_t'(mem_req_addr_o);
            check_addr(offset, cur_addr - periph_pkg::MEM_BASE, "mem_req_addr_o");
            check_flag(mem_req_write_o, cur_write, "mem_req_write_o");
            wr    = mem_req_write_o;
            wdata = mem_req_wdata_o;
            mem_req_ready_i = 1'b1;
            @(negedge clk_i);
            mem_req_ready_i = 1'b0;
            delay = $random(seed) & 3;
            repeat (delay) @(negedge clk_i);
            if (wr) begin
                mem_store[offset] = wdata;
                mem_rsp_rdata_i   = '0;
            end else begin
                mem_rsp_rdata_i = mem_store.exists(offset) ? mem_store[offset] : '0;
            end
            mem_rsp_valid_i = 1'b1;
            @(negedge clk_i);
            mem_rsp_valid_i = 1'b0;
        end
    end

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles, the test did not finish", cycle_count));
        end
    end

    initial begin : stimulus
        periph_pkg::data_t rdata;
        periph_pkg::resp_e err;
        periph_pkg::resp_e exp_err;
        logic              irq_at_rsp;
        logic              ext_seen;
        logic              have_time;
        periph_pkg::data_t last_time;
        rst_n_i          = 1'b0;
        host_req_valid_i = 1'b0;
        host_req_write_i = 1'b0;
        host_req_addr_i  = '0;
        host_req_wdata_i = '0;
        uart_req_ready_i = 1'b0;
        uart_rsp_valid_i = 1'b0;
        uart_rsp_rdata_i = '0;
        uart_rsp_err_i   = 1'b0;
        mem_req_ready_i  = 1'b0;
        mem_rsp_valid_i  = 1'b0;
        mem_rsp_rdata_i  = '0;
        mem_rsp_err_i    = 1'b0;
        have_time        = 1'b0;
        last_time        = '0;
        load_vectors();
        cycle_limit = vec_op.size() * 40 + 200;

        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        check_flag(host_req_ready_o, 1'b1, "host_req_ready_o");
        check_flag(host_rsp_valid_o, 1'b0, "host_rsp_valid_o");
        check_flag(uart_req_valid_o, 1'b0, "uart_req_valid_o");
        check_flag(mem_req_valid_o, 1'b0, "mem_req_valid_o");
        check_flag(timer_irq_o, 1'b0, "timer_irq_o");
        check_data(time_o[31:0], '0, "time_o[31:0]");
        check_data(time_o[63:32], '0, "time_o[63:32]");

        for (int i = 0; i < vec_op.size(); i++) begin
            exp_err = periph_pkg::resp_e'(vec_err[i]);
            if (vec_op[i] == "I") begin
                wait_for_irq(int'(vec_wdata[i]));
            end else begin
                host_access(vec_op[i] == "W" || vec_op[i] == "L", vec_addr[i], vec_wdata[i],
                            rdata, err, irq_at_rsp, ext_seen);
                check_resp(err, exp_err, "host_rsp_err_o");
                if (vec_op[i] == "R" && exp_err == periph_pkg::RESP_OKAY) begin
                    check_data(rdata, vec_rdata[i], "host_rsp_rdata_o");
                end
                if (vec_op[i] == "L") begin
                    check_flag(irq_at_rsp, 1'b0, "timer_irq_o");
                end
                if (vec_op[i] == "T") begin
                    if (have_time && rdata <= last_time) begin
                        abort_run($sformatf("timer value did not increase: %h after %h",
                                            rdata, last_time));
                    end
                    last_time = rdata;
                    have_time = 1'b1;
                end
                if (exp_err == periph_pkg::RESP_ERR && ext_seen) begin
                    abort_run("an external port saw a request for an error access");
                end
            end
        end

        $display(">>> PASS");
        $finish;
    end

endmodule
